// File: run_sim.sh
#!/bin/bash
# Build and run the testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   -f tb.f --top-module tb_msx_glue -o tb_msx_glue

./obj_dir/tb_msx_glue | tee sim.log

if grep -q "Errors found" sim.log; then
   echo "Simulation failed"
   exit 1
fi

echo "Simulation passed"

// File: tb.f
verilog/msx_glue_pkg.sv
verilog/core_ctrl.sv
verilog/sd_route.sv
verilog/cas_ctrl.sv
verilog/mem_arbiter.sv
verilog/video_cfg.sv
verilog/msx_glue_top.sv
verification/tb_msx_glue.sv

// File: verification/tb_msx_glue.sv
`timescale 1ns/100ps
`default_nettype none

module tb_msx_glue;
   import msx_glue_pkg::*;

   localparam int ACT_HOLD   = 64;
   localparam int WAIT_LIMIT = 400;

   logic        clock_bus = 1'b0;
   logic        i_rst_n;
   logic [63:0] i_status;
   logic        i_upload_reset;
   logic        i_fdc_enable;
   logic        o_hard_reset;
   logic        o_core_reset;
   img_t        i_img;
   spi_t        i_spi_core;
   logic        i_sd_miso;
   logic        i_vsd_miso;
   spi_t        o_sd_pins;
   logic        o_miso_core;
   logic        o_led_user;
   logic [1:0]  o_led_disk;
   dl_t         i_dl;
   logic        i_motor;
   logic        i_cas_dout;
   logic        i_tape_adc;
   logic        i_tape_adc_act;
   logic        o_play;
   logic        o_rewind;
   logic        o_tape_in;
   logic        o_is_cas;
   ddr_req_t    i_ddr_dl;
   ddr_req_t    i_ddr_cas;
   logic        i_upload;
   sdram_req_t  i_sdram_upload;
   sdram_req_t  i_sdram_cpu;
   logic [7:0]  i_sdram_dout;
   logic        i_sdram_ce;
   ddr_req_t    o_ddr;
   sdram_req_t  o_sdram_ch1;
   logic [7:0]  o_ram_dout;
   logic        i_forced_scandoubler;
   logic [11:0] i_hdmi_width;
   logic [11:0] i_hdmi_height;
   video_cfg_t  o_video;

   int          errors;
   int          checks;
   logic [31:0] rng;

   msx_glue_top #(
      .P_ACT_HOLD (ACT_HOLD)
   ) dut0 (.*);

   initial begin
      forever #2 clock_bus = ~clock_bus;
   end

   // ==================================================
   // Helpers
   // ==================================================
   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   task automatic compare(input string name, input logic [63:0] expected,
                          input logic [63:0] actual);
      checks++;
      assert (actual == expected) else begin
         errors++;
         $display("error: %s expected %0h actual %0h", name, expected, actual);
      end
   endtask

   // Cycles until the physical disk LED reaches the given level
   task automatic wait_disk_led(input logic level, output int cycles);
      cycles = 0;
      while (o_led_disk[0] !== level && cycles < WAIT_LIMIT) begin
         @(negedge clock_bus);
         cycles++;
      end
      checks++;
      assert (o_led_disk[0] === level) else begin
         errors++;
         $display("timeout: disk activity LED never reached %0b", level);
      end
   endtask

   // ==================================================
   // Directed tests
   // ==================================================
   task automatic resets_follow_rules();
      logic exp_hard;
      logic exp_core;
      for (int i = 0; i < 100; i++) begin
         rng = xorshift(rng);
         i_status[31:0] = rng;
         rng = xorshift(rng);
         i_status[63:32] = rng;
         // Sparse reset sources so both levels show up
         i_status[ST_RESET]       = rng[0] & rng[1];
         i_status[ST_ROM_EJECT]   = rng[2] & rng[3];
         i_status[ST_RESET_CLOSE] = rng[4] & rng[5];
         i_status[ST_RESET_MOUNT] = rng[6];
         i_upload_reset           = rng[7] & rng[8];
         i_fdc_enable             = rng[9];
         i_img.mounted            = rng[18:12];
         exp_hard = i_upload_reset | i_status[ST_RESET];
         exp_core = exp_hard | i_status[ST_ROM_EJECT] | i_status[ST_RESET_CLOSE]
                    | (i_status[ST_RESET_MOUNT] & i_img.mounted[SD_SLOT] & i_fdc_enable);
         @(negedge clock_bus);
         compare("hard_reset", exp_hard, o_hard_reset);
         compare("core_reset", exp_core, o_core_reset);
      end
      i_status       = '0;
      i_upload_reset = 1'b0;
      i_fdc_enable   = 1'b0;
      i_img.mounted  = '0;
      @(negedge clock_bus);
   endtask

   task automatic sd_card_routing();
      int cycles_on;
      int cycles_off;
      // Non-empty image hands the card to the virtual drive
      rng = xorshift(rng);
      i_img.size             = {rng, rng | 32'd1};
      i_img.mounted[SD_SLOT] = 1'b1;
      @(negedge clock_bus);
      i_img.mounted = '0;
      for (int i = 0; i < 8; i++) begin
         rng = xorshift(rng);
         i_spi_core.sck  = rng[0];
         i_spi_core.mosi = rng[1];
         i_sd_miso       = rng[2];
         i_vsd_miso      = rng[3];
         #1;
         compare("virt_cs", 1'b1, o_sd_pins.cs);
         compare("virt_sck", 1'b0, o_sd_pins.sck);
         compare("virt_mosi", 1'b0, o_sd_pins.mosi);
         compare("virt_miso", rng[3], o_miso_core);
         @(negedge clock_bus);
      end
      // Activity shows on the user LED while the image is in use
      i_spi_core.mosi = ~i_spi_core.mosi;
      repeat (2) @(negedge clock_bus);
      compare("led_user_virt", 1'b1, o_led_user);
      compare("led_disk_virt", 1'b0, o_led_disk[0]);
      // Empty image gives the pins back
      i_img.size             = '0;
      i_img.mounted[SD_SLOT] = 1'b1;
      @(negedge clock_bus);
      i_img.mounted = '0;
      for (int i = 0; i < 8; i++) begin
         rng = xorshift(rng);
         i_spi_core.sck  = rng[0];
         i_spi_core.mosi = rng[1];
         i_sd_miso       = rng[2];
         i_vsd_miso      = rng[3];
         #1;
         compare("phys_cs", 1'b0, o_sd_pins.cs);
         compare("phys_sck", rng[0], o_sd_pins.sck);
         compare("phys_mosi", rng[1], o_sd_pins.mosi);
         compare("phys_miso", rng[2], o_miso_core);
         @(negedge clock_bus);
      end
      // Quiet lines first, then a single MOSI edge
      i_spi_core = '0;
      i_sd_miso  = 1'b0;
      i_vsd_miso = 1'b0;
      wait_disk_led(1'b0, cycles_off);
      i_spi_core.mosi = 1'b1;
      wait_disk_led(1'b1, cycles_on);
      checks++;
      assert (cycles_on <= 2) else begin
         errors++;
         $display("activity LED took %0d cycles to light", cycles_on);
      end
      compare("led_user_phys", 1'b0, o_led_user);
      compare("led_disk_high", 1'b1, o_led_disk[1]);
      wait_disk_led(1'b0, cycles_off);
      checks++;
      assert (cycles_on + cycles_off <= ACT_HOLD + 4) else begin
         errors++;
         $display("activity LED stayed on %0d idle cycles", cycles_on + cycles_off);
      end
   endtask

   task automatic cassette_control();
      logic exp_tape;
      i_motor = 1'b0;
      #1;
      compare("play_before_download", 1'b0, o_play);
      @(negedge clock_bus);
      rng = xorshift(rng);
      i_dl.addr     = rng[26:0];
      i_dl.index    = 6'd3;
      i_dl.download = 1'b1;
      repeat (4) @(negedge clock_bus);
      compare("is_cas_other", 1'b0, o_is_cas);
      compare("rewind_other", 1'b0, o_rewind);
      i_dl.download = 1'b0;
      repeat (2) @(negedge clock_bus);
      compare("play_other_index", 1'b0, o_play);
      // Tape file download
      i_dl.index    = 6'd5;
      i_dl.download = 1'b1;
      #1;
      compare("is_cas", 1'b1, o_is_cas);
      compare("rewind_download", 1'b1, o_rewind);
      repeat (4) @(negedge clock_bus);
      i_dl.download = 1'b0;
      @(negedge clock_bus);
      compare("play_ready", 1'b1, o_play);
      compare("rewind_idle", 1'b0, o_rewind);
      i_motor = 1'b1;
      #1;
      compare("play_motor_on", 1'b0, o_play);
      @(negedge clock_bus);
      i_motor                  = 1'b0;
      i_status[ST_TAPE_REWIND] = 1'b1;
      #1;
      compare("rewind_menu", 1'b1, o_rewind);
      @(negedge clock_bus);
      i_status[ST_TAPE_REWIND] = 1'b0;
      for (int i = 0; i < 16; i++) begin
         rng = xorshift(rng);
         i_status[ST_CAS_SRC] = rng[0];
         i_cas_dout           = rng[1];
         i_tape_adc           = rng[2];
         i_tape_adc_act       = rng[3];
         exp_tape = rng[0] ? (rng[2] & rng[3]) : rng[1];
         #1;
         compare("tape_in", exp_tape, o_tape_in);
         @(negedge clock_bus);
      end
      i_status = '0;
   endtask

   task automatic memory_arbitration();
      ddr_req_t   exp_ddr;
      sdram_req_t exp_ch1;
      for (int i = 0; i < 64; i++) begin
         rng = xorshift(rng);
         i_ddr_dl.addr = rng[27:0];
         i_ddr_dl.rd   = rng[28];
         i_upload      = rng[29];
         i_sdram_ce    = rng[30];
         rng = xorshift(rng);
         i_ddr_cas = {rng[27:0], rng[28]};
         rng = xorshift(rng);
         i_sdram_upload = {rng[4:0], rng};
         rng = xorshift(rng);
         i_sdram_cpu = {rng[4:0], rng};
         rng = xorshift(rng);
         i_sdram_dout = rng[7:0];
         exp_ddr = i_ddr_dl.rd ? i_ddr_dl : i_ddr_cas;
         if (i_upload) begin
            exp_ch1     = i_sdram_upload;
            exp_ch1.rnw = 1'b0;
         end else begin
            exp_ch1 = i_sdram_cpu;
         end
         #1;
         compare("ddr_req", exp_ddr, o_ddr);
         compare("sdram_ch1", exp_ch1, o_sdram_ch1);
         compare("ram_dout", i_sdram_ce ? i_sdram_dout : 8'hFF, o_ram_dout);
         @(negedge clock_bus);
      end
   endtask

   task automatic video_decode();
      logic [11:0] exp_arx;
      logic [11:0] exp_ary;
      logic [1:0]  exp_sl;
      logic        exp_sd;
      i_hdmi_width  = 12'd1920;
      i_hdmi_height = 12'd1080;
      for (int f = 0; f < 2; f++) begin
         for (int a = 0; a < 4; a++) begin
            for (int s = 0; s < 8; s++) begin
               i_forced_scandoubler    = f[0];
               i_status[ST_AR +: 2]    = a[1:0];
               i_status[ST_SCALE +: 3] = s[2:0];
               exp_arx = (a == 0) ? 12'd4 : 12'(a - 1);
               exp_ary = (a == 0) ? 12'd3 : 12'd0;
               exp_sl  = (s == 0) ? 2'd0 : 2'(s - 1);
               exp_sd  = f[0] | (s != 0);
               @(negedge clock_bus);
               compare("arx", exp_arx, o_video.arx);
               compare("ary", exp_ary, o_video.ary);
               compare("sl", exp_sl, o_video.sl);
               compare("scandoubler", exp_sd, o_video.scandoubler);
               compare("hq2x", s == 1, o_video.hq2x);
               compare("video_scale", s, o_video.scale);
               compare("crop_size", exp_sd ? 0 : 216, o_video.crop_size);
            end
         end
      end
      // Crop follows the HDMI size one cycle late
      i_forced_scandoubler    = 1'b0;
      i_status[ST_SCALE +: 3] = 3'd0;
      i_hdmi_width            = 12'd1280;
      i_hdmi_height           = 12'd720;
      @(negedge clock_bus);
      compare("crop_720p", 0, o_video.crop_size);
      i_hdmi_width  = 12'd1920;
      i_hdmi_height = 12'd1080;
      #1;
      compare("crop_before_edge", 0, o_video.crop_size);
      @(negedge clock_bus);
      compare("crop_216p", 216, o_video.crop_size);
      i_status = '0;
   endtask

   // ==================================================
   // Main sequence
   // ==================================================
   initial begin
      errors               = 0;
      checks               = 0;
      rng                  = 32'd89609;
      i_rst_n              = 1'b0;
      i_status             = '0;
      i_upload_reset       = 1'b0;
      i_fdc_enable         = 1'b0;
      i_img                = '0;
      i_spi_core           = '0;
      i_sd_miso            = 1'b0;
      i_vsd_miso           = 1'b0;
      i_dl                 = '0;
      i_motor              = 1'b0;
      i_cas_dout           = 1'b0;
      i_tape_adc           = 1'b0;
      i_tape_adc_act       = 1'b0;
      i_ddr_dl             = '0;
      i_ddr_cas            = '0;
      i_upload             = 1'b0;
      i_sdram_upload       = '0;
      i_sdram_cpu          = '0;
      i_sdram_dout         = '0;
      i_sdram_ce           = 1'b0;
      i_forced_scandoubler = 1'b0;
      i_hdmi_width         = '0;
      i_hdmi_height        = '0;
      repeat (16) @(negedge clock_bus);
      compare("hard_reset_held", 1'b1, o_hard_reset);
      compare("core_reset_held", 1'b1, o_core_reset);
      i_rst_n = 1'b1;
      #1;
      compare("hard_reset_release", 1'b1, o_hard_reset);
      compare("core_reset_release", 1'b1, o_core_reset);
      compare("led_disk_reset", 2'b10, o_led_disk);
      compare("vsd_cs_reset", 1'b0, o_sd_pins.cs);
      @(negedge clock_bus);
      resets_follow_rules();
      sd_card_routing();
      cassette_control();
      memory_arbitration();
      video_decode();
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/cas_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module cas_ctrl (
   input  wire                          clock_bus,
   input  wire                          i_rst_n,
   input  wire msx_glue_pkg::settings_t i_settings,
   input  wire                          i_core_reset,
   input  wire msx_glue_pkg::dl_t       i_dl,
   input  wire                          i_motor,
   input  wire                          i_cas_dout,
   input  wire                          i_tape_adc,
   input  wire                          i_tape_adc_act,
   output logic                         o_play,
   output logic                         o_rewind,
   output logic                         o_tape_in,
   output logic                         o_is_cas
);
   import msx_glue_pkg::*;

   cas_state_e state;
   cas_state_e state_next;

   // Host is streaming a cassette file
   assign o_is_cas = i_dl.download & (i_dl.index == CAS_INDEX);

   // ==================================================
   // Tape image FSM
   // ==================================================
   always_comb begin
      state_next = state;
      case (state)
         CAS_EMPTY, CAS_READY: begin
            if (o_is_cas) begin
               state_next = CAS_DOWNLOAD;
            end
         end
         CAS_DOWNLOAD: begin
            if (!o_is_cas) begin
               state_next = CAS_READY;
            end
         end
         default: state_next = CAS_EMPTY;
      endcase
   end

   always_ff @(posedge clock_bus or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= CAS_EMPTY;
      end else begin
         state <= state_next;
      end
   end

   // Player runs while the MSX has the motor relay released
   assign o_play   = ~i_motor & (state == CAS_READY);
   assign o_rewind = i_settings.tape_rewind | o_is_cas | i_core_reset;

   // ADC bit counts only while the front end sees a signal
   assign o_tape_in = (i_settings.cas_src == CAS_AUDIO_FILE) ? i_cas_dout
                                                             : (i_tape_adc & i_tape_adc_act);

endmodule

`default_nettype wire

// File: verilog/core_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module core_ctrl (
   input  wire                              clock_bus,
   input  wire                              i_rst_n,
   input  wire [63:0]                       i_status,
   input  wire                              i_upload_reset,
   input  wire [msx_glue_pkg::VDNUM-1:0]    i_img_mounted,
   input  wire                              i_fdc_enable,
   output msx_glue_pkg::settings_t          o_settings,
   output logic                             o_hard_reset,
   output logic                             o_core_reset
);
   import msx_glue_pkg::*;

   logic hard_next;
   logic core_next;
   logic mount_reset;

   // ==================================================
   // Status word decode
   // ==================================================
   always_comb begin
      o_settings.ar                = i_status[ST_AR +: AR_W];
      o_settings.scale             = i_status[ST_SCALE +: SCALE_W];
      o_settings.tape_rewind       = i_status[ST_TAPE_REWIND];
      o_settings.rom_eject         = i_status[ST_ROM_EJECT];
      o_settings.reset_after_mount = i_status[ST_RESET_MOUNT];
      o_settings.cas_src           = cas_src_e'(i_status[ST_CAS_SRC]);
      o_settings.sram_save         = i_status[ST_SRAM_SAVE];
      o_settings.sram_load         = i_status[ST_SRAM_LOAD];
   end

   // Reset after a new SD image, only with the disk controller present
   assign mount_reset = o_settings.reset_after_mount & i_img_mounted[SD_SLOT] & i_fdc_enable;

   assign hard_next = i_upload_reset | i_status[ST_RESET];
   assign core_next = hard_next | o_settings.rom_eject | i_status[ST_RESET_CLOSE] | mount_reset;

   // ==================================================
   // Registered resets
   // ==================================================
   // Both held active through reset and the first edge after it
   always_ff @(posedge clock_bus or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_hard_reset <= 1'b1;
         o_core_reset <= 1'b1;
      end else begin
         o_hard_reset <= hard_next;
         o_core_reset <= core_next;
      end
   end

   // The machine never sees a hard reset without the core reset
   a_hard_implies_core : assert property (
      @(posedge clock_bus) disable iff (!i_rst_n)
      o_hard_reset |-> o_core_reset
   );

endmodule

`default_nettype wire

// File: verilog/mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
   input  wire msx_glue_pkg::ddr_req_t   i_ddr_dl,
   input  wire msx_glue_pkg::ddr_req_t   i_ddr_cas,
   input  wire                           i_upload,
   input  wire msx_glue_pkg::sdram_req_t i_sdram_upload,
   input  wire msx_glue_pkg::sdram_req_t i_sdram_cpu,
   input  wire [7:0]                     i_sdram_dout,
   input  wire                           i_sdram_ce,
   output msx_glue_pkg::ddr_req_t        o_ddr,
   output msx_glue_pkg::sdram_req_t      o_sdram_ch1,
   output logic [7:0]                    o_ram_dout
);
   import msx_glue_pkg::*;

   // Downloader has priority on DDR3
   assign o_ddr = i_ddr_dl.rd ? i_ddr_dl : i_ddr_cas;

   // Upload path only ever writes
   always_comb begin
      if (i_upload) begin
         o_sdram_ch1      = i_sdram_upload;
         o_sdram_ch1.rnw  = 1'b0;
      end else begin
         o_sdram_ch1      = i_sdram_cpu;
      end
   end

   assign o_ram_dout = i_sdram_ce ? i_sdram_dout : RAM_IDLE_DATA;

   always_comb begin
      if (i_upload) begin
         a_upload_writes : assert final (!o_sdram_ch1.rnw);
      end
   end

endmodule

`default_nettype wire

// File: verilog/msx_glue_pkg.sv
`default_nettype none

package msx_glue_pkg;

   // ==================================================
   // Host status word bit positions
   // ==================================================
   localparam int ST_RESET       = 0;
   localparam int ST_AR          = 1;
   localparam int AR_W           = 2;
   localparam int ST_SCALE       = 3;
   localparam int SCALE_W        = 3;
   localparam int ST_TAPE_REWIND = 9;
   localparam int ST_ROM_EJECT   = 10;
   localparam int ST_RESET_MOUNT = 12;
   localparam int ST_RESET_CLOSE = 21;
   localparam int ST_SRAM_SAVE   = 38;
   localparam int ST_SRAM_LOAD   = 39;
   localparam int ST_CAS_SRC     = 40;

   // ==================================================
   // Platform constants
   // ==================================================
   localparam int VDNUM            = 7;
   localparam int SD_SLOT          = 4;
   localparam logic [5:0] CAS_INDEX = 6'd5;
   localparam int ACT_HOLD_DEFAULT = 1_000_000;

   // Video
   localparam logic [11:0] CROP_216P   = 12'd216;
   localparam logic [11:0] HDMI_W_1080 = 12'd1920;
   localparam logic [11:0] HDMI_H_1080 = 12'd1080;
   localparam logic [11:0] AR_DEF_X    = 12'd4;
   localparam logic [11:0] AR_DEF_Y    = 12'd3;

   // Read data while channel 1 is idle
   localparam logic [7:0] RAM_IDLE_DATA = 8'hFF;

   // ==================================================
   // Types
   // ==================================================
   typedef enum logic [0:0] {
      CAS_AUDIO_FILE = 1'b0,
      CAS_AUDIO_ADC  = 1'b1
   } cas_src_e;

   typedef enum logic [1:0] {
      CAS_EMPTY    = 2'd0,
      CAS_DOWNLOAD = 2'd1,
      CAS_READY    = 2'd2
   } cas_state_e;

   typedef struct packed {
      logic [1:0] ar;
      logic [2:0] scale;
      logic       tape_rewind;
      logic       rom_eject;
      logic       reset_after_mount;
      cas_src_e   cas_src;
      logic       sram_save;
      logic       sram_load;
   } settings_t;

   typedef struct packed {
      logic [VDNUM-1:0] mounted;
      logic [63:0]      size;
      logic             readonly;
   } img_t;

   typedef struct packed {
      logic        download;
      logic [5:0]  index;
      logic [26:0] addr;
   } dl_t;

   typedef struct packed {
      logic sck;
      logic mosi;
      logic cs;
   } spi_t;

   typedef struct packed {
      logic [27:0] addr;
      logic        rd;
   } ddr_req_t;

   typedef struct packed {
      logic [26:0] addr;
      logic [7:0]  din;
      logic        req;
      logic        rnw;
   } sdram_req_t;

   typedef struct packed {
      logic [11:0] arx;
      logic [11:0] ary;
      logic [1:0]  sl;
      logic        scandoubler;
      logic        hq2x;
      logic [11:0] crop_size;
      logic [2:0]  scale;
   } video_cfg_t;

endpackage

`default_nettype wire

// File: verilog/msx_glue_top.sv
`timescale 1ns/100ps
`default_nettype none

module msx_glue_top #(
   parameter int P_ACT_HOLD = msx_glue_pkg::ACT_HOLD_DEFAULT
) (
   input  wire                           clock_bus,
   input  wire                           i_rst_n,
   // Host status and resets
   input  wire [63:0]                    i_status,
   input  wire                           i_upload_reset,
   input  wire                           i_fdc_enable,
   output logic                          o_hard_reset,
   output logic                          o_core_reset,
   // SD card
   input  wire msx_glue_pkg::img_t       i_img,
   input  wire msx_glue_pkg::spi_t       i_spi_core,
   input  wire                           i_sd_miso,
   input  wire                           i_vsd_miso,
   output msx_glue_pkg::spi_t            o_sd_pins,
   output logic                          o_miso_core,
   output logic                          o_led_user,
   output logic [1:0]                    o_led_disk,
   // Cassette
   input  wire msx_glue_pkg::dl_t        i_dl,
   input  wire                           i_motor,
   input  wire                           i_cas_dout,
   input  wire                           i_tape_adc,
   input  wire                           i_tape_adc_act,
   output logic                          o_play,
   output logic                          o_rewind,
   output logic                          o_tape_in,
   output logic                          o_is_cas,
   // Memory ports
   input  wire msx_glue_pkg::ddr_req_t   i_ddr_dl,
   input  wire msx_glue_pkg::ddr_req_t   i_ddr_cas,
   input  wire                           i_upload,
   input  wire msx_glue_pkg::sdram_req_t i_sdram_upload,
   input  wire msx_glue_pkg::sdram_req_t i_sdram_cpu,
   input  wire [7:0]                     i_sdram_dout,
   input  wire                           i_sdram_ce,
   output msx_glue_pkg::ddr_req_t        o_ddr,
   output msx_glue_pkg::sdram_req_t      o_sdram_ch1,
   output logic [7:0]                    o_ram_dout,
   // Video
   input  wire                           i_forced_scandoubler,
   input  wire [11:0]                    i_hdmi_width,
   input  wire [11:0]                    i_hdmi_height,
   output msx_glue_pkg::video_cfg_t      o_video
);
   import msx_glue_pkg::*;

   settings_t settings;

   core_ctrl u_core_ctrl (
      .clock_bus      (clock_bus),
      .i_rst_n        (i_rst_n),
      .i_status       (i_status),
      .i_upload_reset (i_upload_reset),
      .i_img_mounted  (i_img.mounted),
      .i_fdc_enable   (i_fdc_enable),
      .o_settings     (settings),
      .o_hard_reset   (o_hard_reset),
      .o_core_reset   (o_core_reset)
   );

   sd_route #(
      .P_ACT_HOLD (P_ACT_HOLD)
   ) u_sd_route (
      .clock_bus   (clock_bus),
      .i_rst_n     (i_rst_n),
      .i_img       (i_img),
      .i_spi_core  (i_spi_core),
      .i_sd_miso   (i_sd_miso),
      .i_vsd_miso  (i_vsd_miso),
      .o_sd_pins   (o_sd_pins),
      .o_miso_core (o_miso_core),
      .o_led_user  (o_led_user),
      .o_led_disk  (o_led_disk)
   );

   cas_ctrl u_cas_ctrl (
      .clock_bus      (clock_bus),
      .i_rst_n        (i_rst_n),
      .i_settings     (settings),
      .i_core_reset   (o_core_reset),
      .i_dl           (i_dl),
      .i_motor        (i_motor),
      .i_cas_dout     (i_cas_dout),
      .i_tape_adc     (i_tape_adc),
      .i_tape_adc_act (i_tape_adc_act),
      .o_play         (o_play),
      .o_rewind       (o_rewind),
      .o_tape_in      (o_tape_in),
      .o_is_cas       (o_is_cas)
   );

   mem_arbiter u_mem_arbiter (
      .i_ddr_dl       (i_ddr_dl),
      .i_ddr_cas      (i_ddr_cas),
      .i_upload       (i_upload),
      .i_sdram_upload (i_sdram_upload),
      .i_sdram_cpu    (i_sdram_cpu),
      .i_sdram_dout   (i_sdram_dout),
      .i_sdram_ce     (i_sdram_ce),
      .o_ddr          (o_ddr),
      .o_sdram_ch1    (o_sdram_ch1),
      .o_ram_dout     (o_ram_dout)
   );

   video_cfg u_video_cfg (
      .clock_bus            (clock_bus),
      .i_rst_n              (i_rst_n),
      .i_settings           (settings),
      .i_forced_scandoubler (i_forced_scandoubler),
      .i_hdmi_width         (i_hdmi_width),
      .i_hdmi_height        (i_hdmi_height),
      .o_video              (o_video)
   );

endmodule

`default_nettype wire

// File: verilog/sd_route.sv
`timescale 1ns/100ps
`default_nettype none

module sd_route #(
   parameter int P_ACT_HOLD = msx_glue_pkg::ACT_HOLD_DEFAULT
) (
   input  wire                     clock_bus,
   input  wire                     i_rst_n,
   input  wire msx_glue_pkg::img_t i_img,
   input  wire msx_glue_pkg::spi_t i_spi_core,
   input  wire                     i_sd_miso,
   input  wire                     i_vsd_miso,
   output msx_glue_pkg::spi_t      o_sd_pins,
   output logic                    o_miso_core,
   output logic                    o_led_user,
   output logic [1:0]              o_led_disk
);
   import msx_glue_pkg::*;

   localparam int unsigned ACT_W = $clog2(P_ACT_HOLD + 1);
   localparam logic [ACT_W-1:0] ACT_MAX = ACT_W'(P_ACT_HOLD);

   logic             vsd_sel;
   logic             old_mosi;
   logic             old_miso;
   logic             toggle;
   logic             sd_act;
   logic [ACT_W-1:0] act_cnt;

   // Virtual card takes over when a non-empty image lands in its slot
   always_ff @(posedge clock_bus or negedge i_rst_n) begin
      if (!i_rst_n) begin
         vsd_sel <= 1'b0;
      end else if (i_img.mounted[SD_SLOT]) begin
         vsd_sel <= |i_img.size;
      end
   end

   // ==================================================
   // Pin routing
   // ==================================================
   always_comb begin
      o_sd_pins.cs   = vsd_sel;
      o_sd_pins.sck  = i_spi_core.sck & ~vsd_sel;
      o_sd_pins.mosi = i_spi_core.mosi & ~vsd_sel;
   end

   assign o_miso_core = vsd_sel ? i_vsd_miso : i_sd_miso;

   // ==================================================
   // Activity detect
   // ==================================================
   assign toggle = (old_mosi ^ i_spi_core.mosi) | (old_miso ^ o_miso_core);

   always_ff @(posedge clock_bus or negedge i_rst_n) begin
      if (!i_rst_n) begin
         old_mosi <= 1'b0;
         old_miso <= 1'b0;
         act_cnt  <= ACT_MAX;
         sd_act   <= 1'b0;
      end else begin
         old_mosi <= i_spi_core.mosi;
         old_miso <= o_miso_core;
         sd_act   <= act_cnt < ACT_MAX;
         if (toggle) begin
            act_cnt <= '0;
         end else if (act_cnt < ACT_MAX) begin
            act_cnt <= act_cnt + 1'b1;
         end
      end
   end

   assign o_led_user = vsd_sel & sd_act;
   // High bit hands the LED over to this core
   assign o_led_disk = {1'b1, ~vsd_sel & sd_act};

   // Physical card stays quiet while the image is in use
   a_no_clock_when_virtual : assert property (
      @(posedge clock_bus) disable iff (!i_rst_n)
      o_sd_pins.cs |-> !o_sd_pins.sck
   );

endmodule

`default_nettype wire

// File: verilog/video_cfg.sv
`timescale 1ns/100ps
`default_nettype none

module video_cfg (
   input  wire                          clock_bus,
   input  wire                          i_rst_n,
   input  wire msx_glue_pkg::settings_t i_settings,
   input  wire                          i_forced_scandoubler,
   input  wire [11:0]                   i_hdmi_width,
   input  wire [11:0]                   i_hdmi_height,
   output msx_glue_pkg::video_cfg_t     o_video
);
   import msx_glue_pkg::*;

   logic [2:0] sl_full;
   logic       scandoubler;
   logic       en216p;

   // Scanline level follows the filter choice, HQ2x has none
   assign sl_full     = (i_settings.scale != 3'd0) ? i_settings.scale - 3'd1 : 3'd0;
   assign scandoubler = i_forced_scandoubler | (i_settings.scale != 3'd0);

   // 216p crop on a native 1080p output only
   always_ff @(posedge clock_bus or negedge i_rst_n) begin
      if (!i_rst_n) begin
         en216p <= 1'b0;
      end else begin
         en216p <= (i_hdmi_width == HDMI_W_1080) && (i_hdmi_height == HDMI_H_1080)
                   && !scandoubler;
      end
   end

   always_comb begin
      // Original is 4:3, other choices select a custom ratio slot
      o_video.arx         = (i_settings.ar == 2'd0) ? AR_DEF_X
                                                    : {10'b0, i_settings.ar - 2'd1};
      o_video.ary         = (i_settings.ar == 2'd0) ? AR_DEF_Y : 12'd0;
      o_video.sl          = sl_full[1:0];
      o_video.scandoubler = scandoubler;
      o_video.hq2x        = i_settings.scale == 3'd1;
      o_video.crop_size   = en216p ? CROP_216P : 12'd0;
      o_video.scale       = i_settings.scale;
   end

endmodule

`default_nettype wire
